//--- Bender.yml
package:
  name: devil_in_fpga

sources:
  - hw/devil_pkg.sv
  - hw/snoop_filter.sv
  - hw/attack_select.sv
  - hw/reply_engine.sv
  - hw/devil_in_fpga.sv
  - target: simulation
    files:
      - sim/tb_checker.sv
      - sim/tb_top.sv

//--- hw/attack_select.sv
module attack_select (
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  devil_pkg::devil_cfg_t i_cfg,
    input  logic                  i_accept,
    output devil_pkg::attack_e    o_attack
);

    devil_pkg::attack_e attack_d;
    logic               osh_used;
    logic               con_active;

    //////////////////////////////////////////////////////////////////////
    // func decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        attack_d = devil_pkg::NONE;
        case (i_cfg.ctrl.func)
            devil_pkg::OSH:
            begin
                if (i_cfg.ctrl.osh_en && !osh_used)
                    attack_d = devil_pkg::ONE_SHOT;
            end
            devil_pkg::CON:
            begin
                if (i_cfg.ctrl.con_en)
                    attack_d = devil_pkg::CONT;
                // con_en dropped mid-run, last delayed reply
                else if (con_active)
                    attack_d = devil_pkg::CONT_LAST;
            end
            devil_pkg::PDT:
            begin
                if (i_cfg.ctrl.pdt_en)
                    attack_d = devil_pkg::TAMPER;
            end
            // ADL and ADT are reserved
            default:
            begin
                attack_d = devil_pkg::NONE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // verdict and run flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_attack   <= devil_pkg::NONE;
            osh_used   <= 1'b0;
            con_active <= 1'b0;
        end
        else
        begin
            if (i_accept)
                o_attack <= attack_d;

            // disabling the block rearms both modes
            if (!i_cfg.ctrl.en)
            begin
                osh_used   <= 1'b0;
                con_active <= 1'b0;
            end
            else if (i_accept)
            begin
                if (attack_d == devil_pkg::ONE_SHOT)
                    osh_used <= 1'b1;
                if (attack_d == devil_pkg::CONT)
                    con_active <= 1'b1;
                else if (attack_d == devil_pkg::CONT_LAST)
                    con_active <= 1'b0;
            end
        end
    end

    // one delayed reply per enable window
    a_one_shot_once: assert property (
        @(posedge ace_aclk) disable iff (!ace_aresetn)
        (i_accept && attack_d == devil_pkg::ONE_SHOT)
            |=> !(i_accept && attack_d == devil_pkg::ONE_SHOT) until !i_cfg.ctrl.en
    );

endmodule

//--- hw/devil_in_fpga.sv
module devil_in_fpga #(
    parameter int ADDR_W = devil_pkg::SNAP_ADDR_W,
    parameter int DATA_W = devil_pkg::REPLY_DATA_W,
    parameter int CNT_W  = 32
)(
    input  logic                   ace_aclk,
    input  logic                   ace_aresetn,
    input  devil_pkg::devil_cfg_t  i_cfg,
    input  devil_pkg::snoop_snap_t i_snap,
    input  logic [DATA_W-1:0]      i_wdata,
    input  logic                   i_trigger,
    input  logic                   i_crready,
    input  logic                   i_cdready,
    output devil_pkg::reply_t      o_reply_bus,
    output logic                   o_reply,
    output logic                   o_end,
    output logic                   o_busy
);

    logic               accept;
    logic               match;
    devil_pkg::attack_e attack;

    //////////////////////////////////////////////////////////////////////
    // both judges register their verdict on the same accept edge
    //////////////////////////////////////////////////////////////////////

    snoop_filter #(
        .ADDR_W (ADDR_W)
    ) u_filter (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_cfg       (i_cfg),
        .i_snap      (i_snap),
        .i_accept    (accept),
        .o_match     (match)
    );

    attack_select u_select (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_cfg       (i_cfg),
        .i_accept    (accept),
        .o_attack    (attack)
    );

    reply_engine #(
        .DATA_W (DATA_W),
        .CNT_W  (CNT_W)
    ) u_engine (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_cfg       (i_cfg),
        .i_trigger   (i_trigger),
        .i_match     (match),
        .i_attack    (attack),
        .i_wdata     (i_wdata),
        .i_crready   (i_crready),
        .i_cdready   (i_cdready),
        .o_accept    (accept),
        .o_reply_bus (o_reply_bus),
        .o_reply     (o_reply),
        .o_end       (o_end),
        .o_busy      (o_busy)
    );

endmodule

//--- hw/devil_pkg.sv
package devil_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int SNOOP_W  = 4;
    localparam int CRRESP_W = 5;

    // struct widths, the top-level ADDR_W and DATA_W must agree
    localparam int SNAP_ADDR_W  = 44;
    localparam int REPLY_DATA_W = 128;

    //////////////////////////////////////////////////////////////////////
    // control codes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0]
    {
        OSH = 4'd0,
        CON = 4'd1,
        ADL = 4'd2,
        ADT = 4'd3,
        PDT = 4'd4
    } func_e;

    typedef enum logic [3:0]
    {
        FUZZ         = 4'd0,
        LATE_CRVALID = 4'd1,
        LATE_CDVALID = 4'd2,
        LATE_CDLAST  = 4'd3
    } test_e;

    // selector verdict, NONE ends in a dummy reply
    typedef enum logic [2:0]
    {
        NONE,
        ONE_SHOT,
        CONT,
        CONT_LAST,
        TAMPER
    } attack_e;

    //////////////////////////////////////////////////////////////////////
    // config and snoop
    //////////////////////////////////////////////////////////////////////

    // control register, en in bit 0
    typedef struct packed
    {
        logic [10:0]         spare;
        logic                pdt_en;
        logic                adt_en;
        logic                adl_en;
        logic                con_en;
        logic                osh_en;
        logic                addr_flt;
        logic                ac_flt;
        logic [CRRESP_W-1:0] crresp;
        logic [3:0]          func;
        logic [3:0]          test;
        logic                en;
    } devil_ctrl_t;

    typedef struct packed
    {
        devil_ctrl_t         ctrl;
        logic [31:0]         base_addr;
        logic [31:0]         addr_size;
        logic [31-SNOOP_W:0] snoop_rsvd;
        logic [SNOOP_W-1:0]  snoop_match;
        logic [26:0]         delay_rsvd;
        logic [4:0]          delay_exp;
    } devil_cfg_t;

    typedef struct packed
    {
        logic [SNAP_ADDR_W-1:0] addr;
        logic [SNOOP_W-1:0]     snoop;
    } snoop_snap_t;

    // CR/CD channel towards the interconnect
    typedef struct packed
    {
        logic [CRRESP_W-1:0]     crresp;
        logic [REPLY_DATA_W-1:0] rdata;
        logic                    crvalid;
        logic                    cdvalid;
        logic                    cdlast;
    } reply_t;

endpackage

//--- hw/reply_engine.sv
module reply_engine #(
    parameter int DATA_W = devil_pkg::REPLY_DATA_W,
    parameter int CNT_W  = 32
)(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  devil_pkg::devil_cfg_t i_cfg,
    input  logic                  i_trigger,
    input  logic                  i_match,
    input  devil_pkg::attack_e    i_attack,
    input  logic [DATA_W-1:0]     i_wdata,
    input  logic                  i_crready,
    input  logic                  i_cdready,
    output logic                  o_accept,
    output devil_pkg::reply_t     o_reply_bus,
    output logic                  o_reply,
    output logic                  o_end,
    output logic                  o_busy
);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_DECIDE,
        ST_WAIT_READY,
        ST_DELAY,
        ST_HOLD,
        ST_FINISH
    } state_e;

    state_e                          state_q;
    logic [2:0]                      flags_q;
    logic [2:0]                      want_q;
    logic [2:0]                      late_q;
    logic [2:0]                      late_d;
    logic                            tamper_q;
    logic                            last_q;
    logic [CNT_W-1:0]                cnt_q;
    logic [CNT_W-1:0]                delay_cycles;
    logic [devil_pkg::CRRESP_W-1:0]  crresp_q;
    logic [DATA_W-1:0]               rdata_q;
    logic                            pass;
    logic                            tamper;
    logic                            last;
    logic                            complete;

    if (DATA_W != devil_pkg::REPLY_DATA_W)
    begin : g_width_check
        $error("reply_engine: DATA_W differs from reply_t data width");
    end

    //////////////////////////////////////////////////////////////////////
    // verdict merge
    //////////////////////////////////////////////////////////////////////

    // a failed filter always forces the dummy reply
    assign pass   = i_match && (i_attack != devil_pkg::NONE);
    assign tamper = i_match && (i_attack == devil_pkg::TAMPER);
    assign last   = i_match && (i_attack inside {devil_pkg::ONE_SHOT,
                                                 devil_pkg::TAMPER,
                                                 devil_pkg::CONT_LAST});

    // D = 0, or 1 << (exp - 1)
    assign delay_cycles = (i_cfg.delay_exp == 5'd0) ? '0
                        : (CNT_W'(1) << (i_cfg.delay_exp - 5'd1));

    // flag order {crvalid, cdvalid, cdlast}
    always_comb
    begin
        late_d = 3'b000;
        if (delay_cycles != '0)
        begin
            case (i_cfg.ctrl.test)
                devil_pkg::LATE_CRVALID: late_d = 3'b100;
                devil_pkg::LATE_CDVALID: late_d = 3'b010;
                devil_pkg::LATE_CDLAST:  late_d = 3'b001;
                default:                 late_d = 3'b000;
            endcase
        end
    end

    assign o_busy   = (state_q != ST_IDLE);
    assign o_accept = i_trigger && (state_q == ST_IDLE);
    assign complete = (state_q == ST_HOLD) && i_crready && (!want_q[1] || i_cdready);

    //////////////////////////////////////////////////////////////////////
    // reply FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state_q  <= ST_IDLE;
            flags_q  <= 3'b000;
            want_q   <= 3'b000;
            late_q   <= 3'b000;
            tamper_q <= 1'b0;
            last_q   <= 1'b0;
            cnt_q    <= '0;
            o_reply  <= 1'b0;
            o_end    <= 1'b0;
        end
        else
        begin
            o_reply <= 1'b0;
            case (state_q)
                ST_IDLE:
                begin
                    if (o_accept)
                        state_q <= ST_DECIDE;
                    if (!i_cfg.ctrl.en)
                        o_end <= 1'b0;
                end
                ST_DECIDE:
                begin
                    // dummy is crvalid alone
                    want_q   <= pass ? 3'b111 : 3'b100;
                    late_q   <= (pass && !tamper) ? late_d : 3'b000;
                    tamper_q <= tamper;
                    last_q   <= last;
                    state_q  <= ST_WAIT_READY;
                end
                ST_WAIT_READY:
                begin
                    if (i_crready)
                    begin
                        flags_q <= want_q & ~late_q;
                        cnt_q   <= CNT_W'(1);
                        state_q <= (late_q != 3'b000) ? ST_DELAY : ST_HOLD;
                    end
                end
                ST_DELAY:
                begin
                    if (cnt_q == delay_cycles)
                    begin
                        flags_q <= want_q;
                        state_q <= ST_HOLD;
                    end
                    else
                    begin
                        cnt_q <= cnt_q + CNT_W'(1);
                    end
                end
                ST_HOLD:
                begin
                    if (complete)
                    begin
                        flags_q <= 3'b000;
                        o_reply <= 1'b1;
                        if (last_q)
                            o_end <= 1'b1;
                        state_q <= ST_FINISH;
                    end
                end
                ST_FINISH:
                begin
                    state_q <= ST_IDLE;
                end
                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // payload, captured once per operation
    always_ff @(posedge ace_aclk)
    begin
        if (state_q == ST_DECIDE)
            crresp_q <= pass ? i_cfg.ctrl.crresp : '0;
        if (state_q == ST_WAIT_READY && i_crready)
            rdata_q <= tamper_q ? i_wdata : '0;
    end

    assign o_reply_bus = '{crresp:  crresp_q,
                           rdata:   rdata_q,
                           crvalid: flags_q[2],
                           cdvalid: flags_q[1],
                           cdlast:  flags_q[0]};

    // raised flags and their payload stay put across back-pressure
    a_reply_hold: assert property (
        @(posedge ace_aclk) disable iff (!ace_aresetn)
        (|flags_q && !complete)
            |=> ((flags_q & $past(flags_q)) == $past(flags_q))
                && $stable(crresp_q) && $stable(rdata_q)
    );

endmodule

//--- hw/snoop_filter.sv
module snoop_filter #(
    parameter int ADDR_W = devil_pkg::SNAP_ADDR_W
)(
    input  logic                   ace_aclk,
    input  logic                   ace_aresetn,
    input  devil_pkg::devil_cfg_t  i_cfg,
    input  devil_pkg::snoop_snap_t i_snap,
    input  logic                   i_accept,
    output logic                   o_match
);

    logic [ADDR_W-1:0] snap_addr;
    logic [31:0]       addr_lo;
    logic [32:0]       win_end;
    logic              type_ok;
    logic              win_ok;

    if (ADDR_W != devil_pkg::SNAP_ADDR_W)
    begin : g_width_check
        $error("snoop_filter: ADDR_W differs from snoop_snap_t address width");
    end

    // window is checked on the low 32 address bits only
    assign snap_addr = i_snap.addr;
    assign addr_lo   = snap_addr[31:0];

    // one extra bit so a window reaching 4G does not wrap
    assign win_end = {1'b0, i_cfg.base_addr} + {1'b0, i_cfg.addr_size};

    assign type_ok = !i_cfg.ctrl.ac_flt || (i_snap.snoop == i_cfg.snoop_match);

    assign win_ok = !i_cfg.ctrl.addr_flt
                 || ((addr_lo >= i_cfg.base_addr) && ({1'b0, addr_lo} < win_end));

    // verdict held for the whole operation
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_match <= 1'b0;
        end
        else if (i_accept)
        begin
            o_match <= type_ok && win_ok;
        end
    end

    // the engine reads o_match long after the trigger
    a_match_stable: assert property (
        @(posedge ace_aclk) disable iff (!ace_aresetn)
        $changed(o_match) |-> $past(i_accept)
    );

endmodule

//--- sim/tb_checker.sv
module tb_checker #(
    parameter int DATA_W = 128
)(
    input  logic                   ace_aclk,
    input  logic                   ace_aresetn,
    input  devil_pkg::devil_cfg_t  i_cfg,
    input  devil_pkg::snoop_snap_t i_snap,
    input  logic [DATA_W-1:0]      i_wdata,
    input  logic                   i_trigger,
    input  logic                   i_crready,
    input  logic                   i_cdready,
    input  devil_pkg::reply_t      i_reply_bus,
    input  logic                   i_reply,
    input  logic                   i_end,
    input  logic                   i_busy,
    output int                     o_value_errs,
    output int                     o_proto_errs,
    output int                     o_accepts,
    output int                     o_replies
);
    timeunit 1ns;
    timeprecision 1ps;

    // selector and engine model
    logic               osh_used;
    logic               con_active;
    logic               mdl_busy;
    logic               mdl_fin;
    logic               mdl_end;
    logic               exp_reply;
    logic               last;
    logic               idle;
    logic               in_reply;
    logic               hit;
    logic               pass;
    logic               tamper;
    logic [2:0]         want;
    logic [2:0]         late;
    logic [2:0]         flags;
    logic [4:0]         exp_crresp;
    logic [DATA_W-1:0]  exp_rdata;
    devil_pkg::attack_e att;
    int                 delay_d;
    int                 i;
    longint             cyc;
    longint             rise [3];

    initial
    begin
        o_value_errs = 0;
        o_proto_errs = 0;
        o_accepts    = 0;
        o_replies    = 0;
    end

    task automatic mismatch(input string msg);
        o_value_errs++;
        $display("FAILED %0d ns: %s", $time, msg);
    endtask

    task automatic violation(input string msg);
        o_proto_errs++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    function automatic string flag_name(input int k);
        flag_name = (k == 2) ? "crvalid" : (k == 1) ? "cdvalid" : "cdlast";
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////////////////////////

    function automatic logic snoop_passes(input devil_pkg::devil_cfg_t c,
                                          input devil_pkg::snoop_snap_t s);
        logic [32:0] lo;
        logic [32:0] base;
        logic [32:0] lim;
        lo   = {1'b0, s.addr[31:0]};
        base = {1'b0, c.base_addr};
        lim  = base + {1'b0, c.addr_size};
        snoop_passes = (!c.ctrl.ac_flt || (s.snoop == c.snoop_match))
                    && (!c.ctrl.addr_flt || ((lo >= base) && (lo < lim)));
    endfunction

    function automatic devil_pkg::attack_e pick_attack(input devil_pkg::devil_ctrl_t c,
                                                       input logic used,
                                                       input logic active);
        pick_attack = devil_pkg::NONE;
        if (c.func == 4'd0 && c.osh_en && !used)
            pick_attack = devil_pkg::ONE_SHOT;
        else if (c.func == 4'd1)
        begin
            if (c.con_en)
                pick_attack = devil_pkg::CONT;
            else if (active)
                pick_attack = devil_pkg::CONT_LAST;
        end
        else if (c.func == 4'd4 && c.pdt_en)
            pick_attack = devil_pkg::TAMPER;
    endfunction

    function automatic int delay_of(input logic [4:0] e);
        delay_of = (e == 5'd0) ? 0 : (1 << (e - 1));
    endfunction

    // called on the completion edge with all wanted flags up
    task automatic check_timing();
        int base;
        int li;
        int k;
        base = -1;
        li   = -1;
        for (k = 2; k >= 0; k--)
        begin
            if (late[k])
                li = k;
            else if (want[k] && base < 0)
                base = k;
        end
        for (k = 0; k < 3; k++)
        begin
            if (want[k] && !late[k] && rise[k] != rise[base])
                violation($sformatf("%s and %s did not rise on the same edge",
                                    flag_name(k), flag_name(base)));
        end
        if (li >= 0 && (rise[li] - rise[base]) < delay_d)
            violation($sformatf("%s rose %0d cycles after the others, %0d required",
                                flag_name(li), rise[li] - rise[base], delay_d));
    endtask

    //////////////////////////////////////////////////////////////////////
    // per-edge comparison and then model update
    //////////////////////////////////////////////////////////////////////

    always @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            osh_used   = 1'b0;
            con_active = 1'b0;
            mdl_busy   = 1'b0;
            mdl_fin    = 1'b0;
            mdl_end    = 1'b0;
            exp_reply  = 1'b0;
            want       = 3'b000;
            late       = 3'b000;
            cyc        = 0;
        end
        else
        begin
            cyc   = cyc + 1;
            flags = {i_reply_bus.crvalid, i_reply_bus.cdvalid, i_reply_bus.cdlast};

            if (i_busy !== mdl_busy)
                mismatch($sformatf("o_busy got %b expected %b", i_busy, mdl_busy));
            if (i_reply !== exp_reply)
                mismatch($sformatf("o_reply got %b expected %b", i_reply, exp_reply));
            if (i_end !== mdl_end)
                mismatch($sformatf("o_end got %b expected %b", i_end, mdl_end));
            if (i_reply === 1'b1)
                o_replies++;
            exp_reply = 1'b0;

            idle     = !mdl_busy;
            in_reply = mdl_busy && !mdl_fin;

            if (!in_reply)
            begin
                if (flags !== 3'b000)
                    mismatch($sformatf("flags %b up outside a reply", flags));
            end
            else
            begin
                if ((flags & ~want) != 3'b000)
                    mismatch($sformatf("flags %b outside the wanted set %b", flags, want));
                if (flags != 3'b000)
                begin
                    if (i_reply_bus.crresp !== exp_crresp)
                        mismatch($sformatf("crresp got %h expected %h",
                                           i_reply_bus.crresp, exp_crresp));
                    if (i_reply_bus.rdata !== exp_rdata)
                        mismatch($sformatf("rdata got %h expected %h",
                                           i_reply_bus.rdata, exp_rdata));
                end
                for (i = 0; i < 3; i++)
                begin
                    if (flags[i] === 1'b1 && rise[i] < 0)
                        rise[i] = cyc;
                    else if (flags[i] !== 1'b1 && rise[i] >= 0)
                        violation($sformatf("%s dropped before the reply completed",
                                            flag_name(i)));
                end
            end

            // FINISH goes back to idle on the edge after completion
            if (mdl_fin)
            begin
                mdl_busy = 1'b0;
                mdl_fin  = 1'b0;
            end
            else if (in_reply && flags == want && i_crready && (!want[1] || i_cdready))
            begin
                check_timing();
                if (last)
                    mdl_end = 1'b1;
                exp_reply = 1'b1;
                mdl_fin   = 1'b1;
            end

            if (idle && !i_cfg.ctrl.en)
                mdl_end = 1'b0;

            att = pick_attack(i_cfg.ctrl, osh_used, con_active);

            if (idle && i_trigger)
            begin
                o_accepts++;
                hit        = snoop_passes(i_cfg, i_snap);
                pass       = hit && (att != devil_pkg::NONE);
                tamper     = hit && (att == devil_pkg::TAMPER);
                last       = hit && (att == devil_pkg::ONE_SHOT || att == devil_pkg::TAMPER
                                     || att == devil_pkg::CONT_LAST);
                want       = pass ? 3'b111 : 3'b100;
                delay_d    = delay_of(i_cfg.delay_exp);
                late       = 3'b000;
                if (pass && !tamper && delay_d != 0)
                begin
                    case (i_cfg.ctrl.test)
                        4'd1: late = 3'b100;
                        4'd2: late = 3'b010;
                        4'd3: late = 3'b001;
                        default: late = 3'b000;
                    endcase
                end
                exp_crresp = pass ? i_cfg.ctrl.crresp : 5'd0;
                exp_rdata  = tamper ? i_wdata : '0;
                rise[0]    = -1;
                rise[1]    = -1;
                rise[2]    = -1;
                mdl_busy   = 1'b1;
            end

            // run flags rearmed by en low
            if (!i_cfg.ctrl.en)
            begin
                osh_used   = 1'b0;
                con_active = 1'b0;
            end
            else if (idle && i_trigger)
            begin
                if (att == devil_pkg::ONE_SHOT)
                    osh_used = 1'b1;
                if (att == devil_pkg::CONT)
                    con_active = 1'b1;
                else if (att == devil_pkg::CONT_LAST)
                    con_active = 1'b0;
            end
        end
    end

endmodule

//--- sim/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W     = 44;
    localparam int DATA_W     = 128;
    localparam int CNT_W      = 32;
    localparam int CLK_PERIOD = 8;
    localparam int N_OPS      = 300;
    localparam int OP_CYCLES  = 64 + 40;

    logic                   ace_aclk;
    logic                   ace_aresetn;
    devil_pkg::devil_cfg_t  cfg;
    devil_pkg::snoop_snap_t snap;
    logic [DATA_W-1:0]      wdata;
    logic                   trigger;
    logic                   crready;
    logic                   cdready;
    devil_pkg::reply_t      reply_bus;
    logic                   reply;
    logic                   end_flag;
    logic                   busy;
    int                     value_errs;
    int                     proto_errs;
    int                     accepts;
    int                     replies;
    int                     other_errs;
    int                     n;
    int                     r;
    integer                 seed;
    integer                 rdy_seed;

    initial
    begin
        ace_aclk = 1'b0;
    end

    always #(CLK_PERIOD / 2) ace_aclk = ~ace_aclk;

    devil_in_fpga #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W),
        .CNT_W  (CNT_W)
    ) u_dut (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_cfg       (cfg),
        .i_snap      (snap),
        .i_wdata     (wdata),
        .i_trigger   (trigger),
        .i_crready   (crready),
        .i_cdready   (cdready),
        .o_reply_bus (reply_bus),
        .o_reply     (reply),
        .o_end       (end_flag),
        .o_busy      (busy)
    );

    tb_checker #(
        .DATA_W (DATA_W)
    ) u_chk (
        .ace_aclk     (ace_aclk),
        .ace_aresetn  (ace_aresetn),
        .i_cfg        (cfg),
        .i_snap       (snap),
        .i_wdata      (wdata),
        .i_trigger    (trigger),
        .i_crready    (crready),
        .i_cdready    (cdready),
        .i_reply_bus  (reply_bus),
        .i_reply      (reply),
        .i_end        (end_flag),
        .i_busy       (busy),
        .o_value_errs (value_errs),
        .o_proto_errs (proto_errs),
        .o_accepts    (accepts),
        .o_replies    (replies)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int roll(input int lim);
        roll = {$random(seed)} % lim;
    endfunction

    // en stays low here, the caller raises it
    task automatic draw_config();
        cfg.ctrl.en       = 1'b0;
        cfg.ctrl.test     = 4'(roll(4));
        cfg.ctrl.func     = 4'(roll(6));
        cfg.ctrl.crresp   = 5'(roll(32));
        cfg.ctrl.ac_flt   = 1'(roll(2));
        cfg.ctrl.addr_flt = 1'(roll(2));
        cfg.ctrl.osh_en   = (roll(4) != 0);
        cfg.ctrl.con_en   = (roll(4) != 0);
        cfg.ctrl.adl_en   = 1'(roll(2));
        cfg.ctrl.adt_en   = 1'(roll(2));
        cfg.ctrl.pdt_en   = (roll(4) != 0);
        cfg.ctrl.spare    = 11'($random(seed));
        cfg.base_addr     = $random(seed);
        cfg.addr_size     = 32'(1 + roll(4096));
        cfg.snoop_rsvd    = 28'($random(seed));
        cfg.snoop_match   = 4'(roll(16));
        cfg.delay_rsvd    = 27'($random(seed));
        // exponent 6 gives the longest delay, 32 cycles
        cfg.delay_exp     = 5'(roll(7));
    endtask

    task automatic new_config();
        cfg.ctrl.en = 1'b0;
        @(negedge ace_aclk);
        draw_config();
        @(negedge ace_aclk);
        cfg.ctrl.en = 1'b1;
    endtask

    // mostly inside the window, half the time the matching snoop code
    task automatic draw_snoop();
        snap.addr = 44'({$random(seed), $random(seed)});
        if (roll(4) != 0)
            snap.addr[31:0] = cfg.base_addr + 32'(roll(int'(cfg.addr_size)));
        snap.snoop = (roll(2) != 0) ? cfg.snoop_match : 4'(roll(16));
        wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // entered on a falling edge, left on one once the engine is idle again
    task automatic run_op();
        while (busy)
            @(negedge ace_aclk);
        draw_snoop();
        trigger = 1'b1;
        @(negedge ace_aclk);
        trigger = 1'b0;
        while (!reply)
            @(negedge ace_aclk);
        while (busy)
            @(negedge ace_aclk);
    endtask

    // clearing con_en with en high ends a continuous run
    task automatic between_ops();
        r = roll(8);
        if (r < 2)
            new_config();
        else if (r < 5 && cfg.ctrl.func == 4'd1)
            cfg.ctrl.con_en = ~cfg.ctrl.con_en;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    always @(negedge ace_aclk)
    begin
        crready = ($random(rdy_seed) & 3) != 0;
        cdready = ($random(rdy_seed) & 3) != 0;
    end

    initial
    begin
        seed        = 32'h6229_8278;
        rdy_seed    = ~seed;
        other_errs  = 0;
        ace_aresetn = 1'b0;
        cfg         = '0;
        snap        = '0;
        wdata       = '0;
        trigger     = 1'b0;
        crready     = 1'b0;
        cdready     = 1'b0;

        repeat (3) @(negedge ace_aclk);
        ace_aresetn = 1'b1;

        new_config();
        for (n = 0; n < N_OPS; n++)
        begin
            run_op();
            between_ops();
        end
        repeat (4) @(negedge ace_aclk);

        if (accepts != N_OPS)
        begin
            $display("only %0d of %0d triggers were accepted", accepts, N_OPS);
            other_errs++;
        end
        if (replies != accepts)
        begin
            $display("%0d replies were seen for %0d accepted triggers", replies, accepts);
            other_errs++;
        end

        $display("errors: %0d value, %0d protocol, %0d other; triggers %0d, replies %0d",
                 value_errs, proto_errs, other_errs, accepts, replies);
        if (value_errs + proto_errs + other_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // budget per operation covers the longest delay plus back-pressure
    initial
    begin
        #(N_OPS * OP_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock periods",
                 N_OPS * OP_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

//--- sources.f
hw/devil_pkg.sv
hw/snoop_filter.sv
hw/attack_select.sv
hw/reply_engine.sv
hw/devil_in_fpga.sv
sim/tb_checker.sv
sim/tb_top.sv
